/* source/stepper_cmd_pkg.sv */
`default_nettype none

package stepper_cmd_pkg;

  // Host command headers
  localparam logic [7:0] cmd_coordinated_step = 8'h01;
  localparam logic [7:0] cmd_motor_enable     = 8'h0a;
  localparam logic [7:0] cmd_motor_brake      = 8'h0b;
  localparam logic [7:0] cmd_clk_divisor      = 8'h0c;
  localparam logic [7:0] cmd_motorconfig      = 8'h10;
  localparam logic [7:0] cmd_api_version      = 8'hfe;

  // Returned by the version query
  localparam logic [7:0] version_major = 8'd1;
  localparam logic [7:0] version_minor = 8'd3;
  localparam logic [7:0] version_patch = 8'd0;

  typedef struct packed {
    logic [7:0]  header;
    logic [55:0] payload;
  } spi_cmd_t;

  // First word of a message is read as a command, later words as raw data
  typedef union packed {
    spi_cmd_t    cmd;
    logic [63:0] raw;
  } spi_word_u;

  typedef struct packed {
    logic [2:0] microsteps;
    logic [7:0] current;
  } driver_cfg_t;

  localparam logic [2:0] microsteps_reset = 3'd2;
  localparam logic [7:0] current_reset    = 8'd140;

endpackage

`default_nettype wire

/* source/motion_pkg.sv */
`default_nettype none

package motion_pkg;

  typedef struct packed {
    logic        cyc;
    logic        stb;
    logic        we;
    logic [3:0]  adr;
    logic [63:0] dat;
  } wb_req_t;

  typedef struct packed {
    logic        ack;
    logic [63:0] dat;
  } wb_rsp_t;

  // Two slots of eight words, address is {slot, word}
  localparam int move_slots = 2;
  localparam int slot_words = 8;

  localparam logic [2:0] word_header    = 3'd0;
  localparam logic [2:0] word_duration  = 3'd1;
  // Axis a uses words base+2a and base+2a+1
  localparam logic [2:0] word_axis_base = 3'd2;

  localparam logic [7:0] reset_divisor = 8'd40;

endpackage

`default_nettype wire

/* source/spi_word_rx.sv */
`default_nettype none

module spi_word_rx (
  input  logic                      CLK,
  input  logic                      resetn,
  input  logic                      SCK,
  input  logic                      CS,
  input  logic                      COPI,
  output logic                      CIPO,
  input  stepper_cmd_pkg::spi_word_u reply,
  output logic                      word_valid,
  output stepper_cmd_pkg::spi_word_u word
);

  // Two sync flops and a third stage for edge detection
  logic [2:0]  sck_s;
  logic [2:0]  cs_s;
  logic [1:0]  copi_s;
  logic        sck_rise;
  logic        sck_fall;
  logic        cs_fall;
  logic        selected;
  logic [5:0]  bit_cnt;
  logic [62:0] rx_shift;
  logic [63:0] tx_shift;

  assign sck_rise = sck_s[1] & ~sck_s[2];
  assign sck_fall = ~sck_s[1] & sck_s[2];
  assign cs_fall  = ~cs_s[1] & cs_s[2];
  assign selected = ~cs_s[1];
  assign CIPO     = tx_shift[63];

  always_ff @(posedge CLK) begin
    if (!resetn) begin
      sck_s      <= '0;
      cs_s       <= '1;
      copi_s     <= '0;
      bit_cnt    <= '0;
      tx_shift   <= '0;
      word_valid <= 1'b0;
    end else begin
      sck_s      <= {sck_s[1:0], SCK};
      cs_s       <= {cs_s[1:0], CS};
      copi_s     <= {copi_s[0], COPI};
      word_valid <= 1'b0;
      if (cs_fall) begin
        bit_cnt  <= '0;
        tx_shift <= reply.raw;
      end else if (selected) begin
        if (sck_rise) begin
          bit_cnt    <= bit_cnt + 6'd1;
          word_valid <= (bit_cnt == 6'd63);
        end
        // Counter wrapped to zero means a word just ended, so take the new reply
        if (sck_fall) begin
          tx_shift <= (bit_cnt == 6'd0) ? reply.raw : {tx_shift[62:0], 1'b0};
        end
      end
    end
  end

  // MSB first
  always_ff @(posedge CLK) begin
    if (selected && sck_rise) begin
      rx_shift <= {rx_shift[61:0], copi_s[1]};
      if (bit_cnt == 6'd63) begin
        word.raw <= {rx_shift, copi_s[1]};
      end
    end
  end

  assert property (@(posedge CLK) disable iff (!resetn)
    word_valid |-> selected);

endmodule

`default_nettype wire

/* source/command_decoder.sv */
`default_nettype none

module command_decoder #(
  parameter int motor_count        = 2,
  parameter int move_duration_bits = 32
) (
  input  logic                                  CLK,
  input  logic                                  resetn,
  input  logic                                  word_valid,
  input  stepper_cmd_pkg::spi_word_u            word,
  output stepper_cmd_pkg::spi_word_u            reply,
  output stepper_cmd_pkg::driver_cfg_t          cfg,
  output logic [motor_count-1:0]                enable,
  output logic [motor_count-1:0]                brake,
  output logic [7:0]                            divisor,
  output logic [motion_pkg::move_slots-1:0]     slot_ready,
  input  logic [motor_count-1:0][31:0]          step_position,
  output motion_pkg::wb_req_t                   wb_req,
  input  motion_pkg::wb_rsp_t                   wb_rsp
);

  localparam logic [2:0] last_word = 3'(motion_pkg::word_axis_base + 2 * motor_count - 1);

  logic [7:0]                   header;
  logic [2:0]                   word_cnt;
  logic                         wr_slot;
  logic                         write_last;
  logic [motor_count-1:0][31:0] pos_snap;
  logic [63:0]                  wr_data;

  // Duration is cut to the counter width
  assign wr_data = (word_cnt == motion_pkg::word_duration) ?
                   64'(word.raw[move_duration_bits-1:0]) : word.raw;

  always_ff @(posedge CLK) begin
    if (!resetn) begin
      header     <= '0;
      word_cnt   <= '0;
      wr_slot    <= 1'b0;
      write_last <= 1'b0;
      slot_ready <= '0;
      reply      <= '0;
      cfg        <= '{microsteps: stepper_cmd_pkg::microsteps_reset,
                      current:    stepper_cmd_pkg::current_reset};
      enable     <= '0;
      brake      <= '0;
      divisor    <= motion_pkg::reset_divisor;
      wb_req     <= '0;
    end else begin
      // Write finished, slot handed over after the last word
      if (wb_rsp.ack) begin
        wb_req.cyc <= 1'b0;
        wb_req.stb <= 1'b0;
        if (write_last) begin
          slot_ready[wr_slot] <= ~slot_ready[wr_slot];
          wr_slot             <= ~wr_slot;
          write_last          <= 1'b0;
        end
      end
      if (word_valid) begin
        reply <= '0;
        if (header == stepper_cmd_pkg::cmd_coordinated_step) begin
          wb_req <= '{cyc: 1'b1, stb: 1'b1, we: 1'b1, adr: {wr_slot, word_cnt},
                      dat: wr_data};
          // Position of the next axis goes out with the following word
          if (word_cnt < motor_count) begin
            reply.raw <= {{32{pos_snap[word_cnt][31]}}, pos_snap[word_cnt]};
          end
          if (word_cnt == last_word) begin
            header     <= '0;
            write_last <= 1'b1;
          end
          word_cnt <= word_cnt + 3'd1;
        end else begin
          word_cnt <= motion_pkg::word_duration;
          case (word.cmd.header)
            stepper_cmd_pkg::cmd_coordinated_step: begin
              header    <= word.cmd.header;
              reply.raw <= {{32{step_position[0][31]}}, step_position[0]};
              wb_req    <= '{cyc: 1'b1, stb: 1'b1, we: 1'b1,
                             adr: {wr_slot, motion_pkg::word_header}, dat: word.raw};
            end
            stepper_cmd_pkg::cmd_motor_enable: enable <= word.cmd.payload[motor_count-1:0];
            stepper_cmd_pkg::cmd_motor_brake:  brake <= word.cmd.payload[motor_count-1:0];
            stepper_cmd_pkg::cmd_clk_divisor:  divisor <= word.cmd.payload[7:0];
            stepper_cmd_pkg::cmd_motorconfig: begin
              cfg.current    <= word.cmd.payload[15:8];
              cfg.microsteps <= word.cmd.payload[2:0];
            end
            stepper_cmd_pkg::cmd_api_version: begin
              reply.raw <= {40'd0, stepper_cmd_pkg::version_major,
                            stepper_cmd_pkg::version_minor, stepper_cmd_pkg::version_patch};
            end
            default: header <= '0;
          endcase
        end
      end
    end
  end

  // Positions frozen at the move header
  always_ff @(posedge CLK) begin
    if (word_valid && header != stepper_cmd_pkg::cmd_coordinated_step &&
        word.cmd.header == stepper_cmd_pkg::cmd_coordinated_step) begin
      pos_snap <= step_position;
    end
  end

  // SPI word spacing leaves room for every memory write
  assert property (@(posedge CLK) disable iff (!resetn)
    word_valid |-> !wb_req.cyc);

endmodule

`default_nettype wire

/* source/move_bus_arbiter.sv */
`default_nettype none

module move_bus_arbiter (
  input  logic                CLK,
  input  logic                resetn,
  input  motion_pkg::wb_req_t m0_req,
  input  motion_pkg::wb_req_t m1_req,
  output motion_pkg::wb_rsp_t m0_rsp,
  output motion_pkg::wb_rsp_t m1_rsp,
  output motion_pkg::wb_req_t s_req,
  input  motion_pkg::wb_rsp_t s_rsp
);

  logic owner;
  logic locked;
  logic sel;

  // Idle bus goes to a requester, master 0 first
  always_comb begin
    if (locked) begin
      sel = owner;
    end else begin
      sel = !m0_req.cyc && m1_req.cyc;
    end
  end

  assign s_req = sel ? m1_req : m0_req;

  always_comb begin
    m0_rsp     = s_rsp;
    m0_rsp.ack = s_rsp.ack & ~sel;
    m1_rsp     = s_rsp;
    m1_rsp.ack = s_rsp.ack & sel;
  end

  // Held until the owner drops cyc
  always_ff @(posedge CLK) begin
    if (!resetn) begin
      owner  <= 1'b0;
      locked <= 1'b0;
    end else begin
      owner  <= sel;
      locked <= s_req.cyc;
    end
  end

  assert property (@(posedge CLK) disable iff (!resetn)
    m0_rsp.ack |-> $past(m0_req.stb && !sel));
  assert property (@(posedge CLK) disable iff (!resetn)
    m1_rsp.ack |-> $past(m1_req.stb && sel));

endmodule

`default_nettype wire

/* source/move_store.sv */
`default_nettype none

module move_store (
  input  logic                CLK,
  input  logic                resetn,
  input  motion_pkg::wb_req_t wb_req,
  output motion_pkg::wb_rsp_t wb_rsp
);

  localparam int depth = motion_pkg::move_slots * motion_pkg::slot_words;

  logic [63:0] mem [0:depth-1];
  logic [63:0] rd_data;
  logic        ack_q;
  logic        access;

  // The ack cycle starts no second access
  assign access = wb_req.cyc && wb_req.stb && !ack_q;
  assign wb_rsp = '{ack: ack_q, dat: rd_data};

  always_ff @(posedge CLK) begin
    if (access && wb_req.we) begin
      mem[wb_req.adr] <= wb_req.dat;
    end
    rd_data <= mem[wb_req.adr];
  end

  always_ff @(posedge CLK) begin
    if (!resetn) begin
      ack_q <= 1'b0;
    end else begin
      ack_q <= access;
    end
  end

  assert property (@(posedge CLK) disable iff (!resetn)
    wb_rsp.ack |-> wb_req.stb && $past(wb_req.stb));

endmodule

`default_nettype wire

/* source/dda_sequencer.sv */
`default_nettype none

module dda_sequencer #(
  parameter int motor_count        = 2,
  parameter int move_duration_bits = 32
) (
  input  logic                              CLK,
  input  logic                              resetn,
  input  logic [7:0]                        divisor,
  input  logic [motion_pkg::move_slots-1:0] slot_ready,
  output logic                              buffer_ready,
  output logic                              move_done,
  output logic [motor_count-1:0]            step,
  output logic [motor_count-1:0]            dir,
  output logic [motor_count-1:0][31:0]      step_position,
  output motion_pkg::wb_req_t               wb_req,
  input  motion_pkg::wb_rsp_t               wb_rsp
);

  localparam logic [1:0] st_idle = 2'd0;
  localparam logic [1:0] st_load = 2'd1;
  localparam logic [1:0] st_exec = 2'd2;
  localparam logic [2:0] last_word = 3'(motion_pkg::word_axis_base + 2 * motor_count - 1);

  logic [1:0]                        state;
  logic [7:0]                        div_cnt;
  logic                              tick;
  logic                              rd_slot;
  logic [2:0]                        rd_idx;
  logic [motion_pkg::move_slots-1:0] slot_done;
  logic [motion_pkg::move_slots-1:0] slot_full;
  logic [move_duration_bits-1:0]     remaining;
  logic [motor_count-1:0][63:0]      acc;
  logic [motor_count-1:0][63:0]      inc;
  logic [motor_count-1:0][63:0]      inc_inc;
  logic [motor_count-1:0][64:0]      sum;

  assign slot_full    = slot_ready ^ slot_done;
  assign buffer_ready = ~&slot_full;

  // One tick every divisor cycles
  always_ff @(posedge CLK) begin
    if (!resetn) begin
      div_cnt <= '0;
      tick    <= 1'b0;
    end else if ({1'b0, div_cnt} + 9'd1 >= {1'b0, divisor}) begin
      div_cnt <= '0;
      tick    <= 1'b1;
    end else begin
      div_cnt <= div_cnt + 8'd1;
      tick    <= 1'b0;
    end
  end

  // Accumulator carry is the step
  always_comb begin
    for (int a = 0; a < motor_count; a++) begin
      sum[a]  = {1'b0, acc[a]} + {1'b0, inc[a]};
      step[a] = tick && (state == st_exec) && sum[a][64];
    end
  end

  always_ff @(posedge CLK) begin
    if (!resetn) begin
      state     <= st_idle;
      rd_slot   <= 1'b0;
      rd_idx    <= '0;
      slot_done <= '0;
      move_done <= 1'b0;
      dir       <= '0;
      wb_req    <= '0;
    end else begin
      move_done <= 1'b0;
      case (state)
        st_idle: begin
          if (slot_full[rd_slot]) begin
            state  <= st_load;
            rd_idx <= motion_pkg::word_header;
            wb_req <= '{cyc: 1'b1, stb: 1'b1, we: 1'b0,
                        adr: {rd_slot, motion_pkg::word_header}, dat: '0};
          end
        end
        st_load: begin
          // Whole slot read as one burst, stb dropped between words
          if (wb_rsp.ack) begin
            wb_req.stb <= 1'b0;
            wb_req.adr <= {rd_slot, rd_idx + 3'd1};
            rd_idx     <= rd_idx + 3'd1;
            if (rd_idx == motion_pkg::word_header) begin
              dir <= wb_rsp.dat[motor_count-1:0];
            end
            if (rd_idx == last_word) begin
              wb_req.cyc <= 1'b0;
              state      <= st_exec;
            end
          end else if (!wb_req.stb) begin
            wb_req.stb <= 1'b1;
          end
        end
        st_exec: begin
          if (tick && remaining <= move_duration_bits'(1)) begin
            slot_done[rd_slot] <= ~slot_done[rd_slot];
            move_done          <= 1'b1;
            rd_slot            <= ~rd_slot;
            state              <= st_idle;
          end
        end
        default: state <= st_idle;
      endcase
    end
  end

  // Move parameters and DDA state
  always_ff @(posedge CLK) begin
    if (state == st_load && wb_rsp.ack) begin
      if (rd_idx == motion_pkg::word_duration) begin
        remaining <= wb_rsp.dat[move_duration_bits-1:0];
      end
      for (int a = 0; a < motor_count; a++) begin
        acc[a] <= '0;
        if (rd_idx == 3'(motion_pkg::word_axis_base + 2 * a)) begin
          inc[a] <= wb_rsp.dat;
        end
        if (rd_idx == 3'(motion_pkg::word_axis_base + 2 * a + 1)) begin
          inc_inc[a] <= wb_rsp.dat;
        end
      end
    end else if (state == st_exec && tick) begin
      remaining <= remaining - move_duration_bits'(1);
      for (int a = 0; a < motor_count; a++) begin
        acc[a] <= sum[a][63:0];
        inc[a] <= inc[a] + inc_inc[a];
      end
    end
  end

  always_ff @(posedge CLK) begin
    if (!resetn) begin
      step_position <= '0;
    end else begin
      for (int a = 0; a < motor_count; a++) begin
        if (step[a]) begin
          step_position[a] <= dir[a] ? step_position[a] + 32'd1 : step_position[a] - 32'd1;
        end
      end
    end
  end

  // A new move must land in a slot that was empty
  assert property (@(posedge CLK) disable iff (!resetn)
    ((slot_ready ^ $past(slot_ready)) & $past(slot_full)) == '0);

endmodule

`default_nettype wire

/* source/stepper_top.sv */
`default_nettype none

module stepper_top #(
  parameter int motor_count        = 2,
  parameter int move_duration_bits = 32
) (
  input  logic                         CLK,
  input  logic                         resetn,
  input  logic                         SCK,
  input  logic                         CS,
  input  logic                         COPI,
  output logic                         CIPO,
  output logic [motor_count-1:0]       step,
  output logic [motor_count-1:0]       dir,
  output logic [motor_count-1:0]       enable,
  output logic [motor_count-1:0]       brake,
  output stepper_cmd_pkg::driver_cfg_t cfg,
  output logic                         buffer_ready,
  output logic                         move_done
);

  stepper_cmd_pkg::spi_word_u        word;
  stepper_cmd_pkg::spi_word_u        reply;
  logic                              word_valid;
  logic [7:0]                        divisor;
  logic [motion_pkg::move_slots-1:0] slot_ready;
  logic [motor_count-1:0][31:0]      step_position;
  motion_pkg::wb_req_t               dec_req;
  motion_pkg::wb_req_t               seq_req;
  motion_pkg::wb_req_t               store_req;
  motion_pkg::wb_rsp_t               dec_rsp;
  motion_pkg::wb_rsp_t               seq_rsp;
  motion_pkg::wb_rsp_t               store_rsp;

  spi_word_rx u_spi_word_rx (
    .CLK(CLK), .resetn(resetn), .SCK(SCK), .CS(CS), .COPI(COPI), .CIPO(CIPO),
    .reply(reply), .word_valid(word_valid), .word(word)
  );

  command_decoder #(
    .motor_count(motor_count), .move_duration_bits(move_duration_bits)
  ) u_command_decoder (
    .CLK(CLK), .resetn(resetn), .word_valid(word_valid), .word(word), .reply(reply),
    .cfg(cfg), .enable(enable), .brake(brake), .divisor(divisor),
    .slot_ready(slot_ready), .step_position(step_position),
    .wb_req(dec_req), .wb_rsp(dec_rsp)
  );

  // Decoder is master 0, sequencer master 1
  move_bus_arbiter u_move_bus_arbiter (
    .CLK(CLK), .resetn(resetn), .m0_req(dec_req), .m1_req(seq_req),
    .m0_rsp(dec_rsp), .m1_rsp(seq_rsp), .s_req(store_req), .s_rsp(store_rsp)
  );

  move_store u_move_store (
    .CLK(CLK), .resetn(resetn), .wb_req(store_req), .wb_rsp(store_rsp)
  );

  dda_sequencer #(
    .motor_count(motor_count), .move_duration_bits(move_duration_bits)
  ) u_dda_sequencer (
    .CLK(CLK), .resetn(resetn), .divisor(divisor), .slot_ready(slot_ready),
    .buffer_ready(buffer_ready), .move_done(move_done), .step(step), .dir(dir),
    .step_position(step_position), .wb_req(seq_req), .wb_rsp(seq_rsp)
  );

endmodule

`default_nettype wire

/* bench/stepper_tb.sv */
`default_nettype none

module stepper_tb;

  timeunit 1ns;
  timeprecision 100ps;

  localparam int motor_count  = 2;
  localparam int move_words   = 2 + 2 * motor_count;
  localparam int move_timeout = 40000;

  logic                         CLK;
  logic                         resetn;
  logic                         SCK;
  logic                         CS;
  logic                         COPI;
  logic                         CIPO;
  logic [motor_count-1:0]       step;
  logic [motor_count-1:0]       dir;
  logic [motor_count-1:0]       enable;
  logic [motor_count-1:0]       brake;
  stepper_cmd_pkg::driver_cfg_t cfg;
  logic                         buffer_ready;
  logic                         move_done;

  int                     seed;
  int                     errors;
  int                     cycle_no;
  int                     done_cnt;
  int                     reviewed;
  int                     moves_sent;
  int                     step_total [0:motor_count-1];
  int                     done_total [0:7][0:motor_count-1];
  logic [motor_count-1:0] done_dir [0:7];
  int                     exp_steps [0:7][0:motor_count-1];
  logic [motor_count-1:0] exp_dir [0:7];
  int                     exp_pos [0:motor_count-1];
  int                     step_times [$];

  stepper_top #(
    .motor_count(motor_count), .move_duration_bits(32)
  ) u_stepper_top (
    .CLK(CLK), .resetn(resetn), .SCK(SCK), .CS(CS), .COPI(COPI), .CIPO(CIPO),
    .step(step), .dir(dir), .enable(enable), .brake(brake), .cfg(cfg),
    .buffer_ready(buffer_ready), .move_done(move_done)
  );

  initial begin
    CLK = 1'b0;
    forever #10 CLK = ~CLK;
  end

  // Step pulses and move ends, sampled away from the rising edge
  always @(negedge CLK) begin
    cycle_no++;
    if (resetn === 1'b1) begin
      for (int a = 0; a < motor_count; a++) begin
        if (step[a]) begin
          step_total[a]++;
        end
      end
      if (step[0]) begin
        step_times.push_back(cycle_no);
      end
      if (move_done && done_cnt < 8) begin
        for (int a = 0; a < motor_count; a++) begin
          done_total[done_cnt][a] = step_total[a];
        end
        done_dir[done_cnt] = dir;
        done_cnt++;
      end
    end
  end

  task automatic abort_run();
    $display("Something failed");
    $fatal(1);
  endtask

  task automatic compare(input string name, input logic [63:0] got,
                         input logic [63:0] expected);
    assert (got === expected) else begin
      $display("ERR t=%0t %s got %0h expected %0h", $time, name, got, expected);
      errors++;
      abort_run();
    end
  endtask

  // Second-order DDA over a number of ticks, counting accumulator carries
  function automatic int dda_steps(input logic [63:0] inc0, input logic [63:0] inc_inc,
                                   input int ticks);
    logic [64:0] sum;
    logic [63:0] acc;
    logic [63:0] inc;
    int          steps;
    acc   = '0;
    inc   = inc0;
    steps = 0;
    for (int t = 0; t < ticks; t++) begin
      sum = {1'b0, acc} + {1'b0, inc};
      if (sum[64]) begin
        steps++;
      end
      acc = sum[63:0];
      inc = inc + inc_inc;
    end
    return steps;
  endfunction

  // One 64-bit SPI mode-0 transfer, SCK at CLK/8
  task automatic spi_word(input logic [63:0] tx, output logic [63:0] rx);
    rx = '0;
    @(posedge CLK);
    CS <= 1'b0;
    repeat (8) @(posedge CLK);
    for (int i = 63; i >= 0; i--) begin
      COPI <= tx[i];
      repeat (3) @(posedge CLK);
      @(negedge CLK);
      rx[i] = CIPO;
      @(posedge CLK);
      SCK <= 1'b1;
      repeat (4) @(posedge CLK);
      SCK <= 1'b0;
    end
    repeat (8) @(posedge CLK);
    CS <= 1'b1;
    repeat (8) @(posedge CLK);
  endtask

  task automatic send_move(input logic [motor_count-1:0] dirs, input int duration,
                           input logic [motor_count-1:0][63:0] inc,
                           input logic [motor_count-1:0][63:0] inc_inc,
                           input bit check_pos);
    logic [63:0] words [0:move_words-1];
    logic [63:0] rx [0:move_words-1];
    int          steps;
    words[0] = {stepper_cmd_pkg::cmd_coordinated_step, 56'(dirs)};
    words[1] = 64'(duration);
    for (int a = 0; a < motor_count; a++) begin
      words[2 + 2 * a] = inc[a];
      words[3 + 2 * a] = inc_inc[a];
    end
    for (int i = 0; i < move_words; i++) begin
      spi_word(words[i], rx[i]);
    end
    // Positions return with words 1..motor_count
    if (check_pos) begin
      for (int a = 0; a < motor_count; a++) begin
        compare($sformatf("position reply axis %0d", a), rx[1 + a],
                64'(longint'(exp_pos[a])));
      end
    end
    for (int i = motor_count + 1; i < move_words; i++) begin
      compare($sformatf("reply word %0d", i), rx[i], 64'd0);
    end
    exp_dir[moves_sent] = dirs;
    for (int a = 0; a < motor_count; a++) begin
      steps                    = dda_steps(inc[a], inc_inc[a], duration);
      exp_steps[moves_sent][a] = steps;
      exp_pos[a]               = dirs[a] ? exp_pos[a] + steps : exp_pos[a] - steps;
    end
    moves_sent++;
  endtask

  task automatic wait_moves(input int target);
    int t;
    t = 0;
    while (done_cnt < target && t < move_timeout) begin
      @(negedge CLK);
      t++;
    end
    assert (done_cnt >= target) else begin
      $display("Timed out at %0t waiting for move %0d to finish", $time, target);
      errors++;
      abort_run();
    end
  endtask

  task automatic wait_buffer(input logic level);
    int t;
    t = 0;
    @(negedge CLK);
    while (buffer_ready !== level && t < 1000) begin
      @(negedge CLK);
      t++;
    end
    assert (buffer_ready === level) else begin
      $display("Timed out at %0t waiting for buffer_ready to become %0b", $time, level);
      errors++;
      abort_run();
    end
  endtask

  // Per-move step counts and directions of every finished move
  task automatic review_moves();
    int prev;
    for (int n = reviewed; n < done_cnt; n++) begin
      for (int a = 0; a < motor_count; a++) begin
        prev = (n > 0) ? done_total[n - 1][a] : 0;
        compare($sformatf("steps move %0d axis %0d", n, a), done_total[n][a] - prev,
                exp_steps[n][a]);
      end
      compare($sformatf("dir move %0d", n), done_dir[n], exp_dir[n]);
    end
    reviewed = done_cnt;
  endtask

  task automatic check_reset_state();
    @(negedge CLK);
    compare("step", step, 64'd0);
    compare("dir", dir, 64'd0);
    compare("enable", enable, 64'd0);
    compare("brake", brake, 64'd0);
    compare("move_done", move_done, 64'd0);
    compare("buffer_ready", buffer_ready, 64'd1);
    compare("cfg", cfg, {stepper_cmd_pkg::microsteps_reset, stepper_cmd_pkg::current_reset});
  endtask

  task automatic configure_driver();
    logic [63:0] rx;
    spi_word({stepper_cmd_pkg::cmd_motor_enable, 56'h3}, rx);
    spi_word({stepper_cmd_pkg::cmd_motor_brake, 56'h2}, rx);
    spi_word({stepper_cmd_pkg::cmd_motorconfig, 56'h5a05}, rx);
    @(negedge CLK);
    compare("enable", enable, 64'h3);
    compare("brake", brake, 64'h2);
    compare("cfg", cfg, {3'd5, 8'h5a});
    // Version bytes come back during the word after the query
    spi_word({stepper_cmd_pkg::cmd_api_version, 56'd0}, rx);
    spi_word(64'd0, rx);
    compare("version reply", rx, {40'd0, stepper_cmd_pkg::version_major,
                                  stepper_cmd_pkg::version_minor,
                                  stepper_cmd_pkg::version_patch});
  endtask

  task automatic random_move(input logic [motor_count-1:0] dirs, input int duration,
                             input bit check_pos);
    logic [motor_count-1:0][63:0] inc;
    logic [motor_count-1:0][63:0] inc_inc;
    for (int a = 0; a < motor_count; a++) begin
      inc[a]     = {$random(seed), $random(seed)};
      inc_inc[a] = 64'(longint'($random(seed))) << 24;
    end
    send_move(dirs, duration, inc, inc_inc, check_pos);
  endtask

  task automatic run_single_move();
    random_move(motor_count'($random(seed)), 120, 1'b1);
    wait_moves(1);
    repeat (100) @(negedge CLK);
    compare("move_done pulses", done_cnt, 64'd1);
    review_moves();
    compare("buffer_ready", buffer_ready, 64'd1);
  endtask

  task automatic run_queued_moves();
    random_move(2'b01, 150, 1'b1);
    random_move(2'b10, 100, 1'b0);
    // Second move lands while the first still runs
    wait_buffer(1'b0);
    wait_moves(3);
    review_moves();
    wait_buffer(1'b1);
  endtask

  task automatic measure_step_spacing();
    logic [63:0]                  rx;
    logic [motor_count-1:0][63:0] inc;
    logic [motor_count-1:0][63:0] inc_inc;
    int                           spacing;
    spi_word({stepper_cmd_pkg::cmd_clk_divisor, 56'd10}, rx);
    inc[0]  = 64'h4000_0000_0000_0000;
    inc[1]  = '0;
    inc_inc = '0;
    // 2^64 / 2^62 ticks per step, ten cycles per tick
    spacing = 4 * 10;
    step_times.delete();
    send_move(2'b11, 20, inc, inc_inc, 1'b1);
    wait_moves(4);
    review_moves();
    assert (step_times.size() >= 2) else begin
      $display("Too few step pulses on axis 0 to measure their spacing");
      errors++;
      abort_run();
    end
    for (int i = 1; i < step_times.size(); i++) begin
      compare("step spacing", step_times[i] - step_times[i - 1], spacing);
    end
  endtask

  initial begin
    resetn     = 1'b0;
    SCK        = 1'b0;
    CS         = 1'b1;
    COPI       = 1'b0;
    seed       = 57369;
    errors     = 0;
    cycle_no   = 0;
    done_cnt   = 0;
    reviewed   = 0;
    moves_sent = 0;
    for (int a = 0; a < motor_count; a++) begin
      step_total[a] = 0;
      exp_pos[a]    = 0;
    end
    repeat (16) @(posedge CLK);
    resetn <= 1'b1;
    check_reset_state();
    configure_driver();
    run_single_move();
    run_queued_moves();
    measure_step_spacing();
    if (errors == 0) begin
      $display("Everything OK");
      $finish;
    end else begin
      abort_run();
    end
  end

endmodule

`default_nettype wire

/* files.f */
source/stepper_cmd_pkg.sv
source/motion_pkg.sv
source/spi_word_rx.sv
source/command_decoder.sv
source/move_bus_arbiter.sv
source/move_store.sv
source/dda_sequencer.sv
source/stepper_top.sv
bench/stepper_tb.sv
